// File: rtl/glay_control_pkg.sv
`default_nettype none

package glay_control_pkg;

  // ------------------------------------------------
  // Field widths
  // ------------------------------------------------
  localparam int engine_id_width = 4;
  localparam int vertex_id_width = 28;
  localparam int status_width    = 12;
  localparam int count_width     = 16;
  localparam int payload_width   = 32;

  // Packet kind, stored as the top bit of a FIFO word
  localparam logic packet_kind_vertex = 1'b0;
  localparam logic packet_kind_done   = 1'b1;

  // Kind bit on top of the payload word
  localparam int packet_width = 1 + payload_width;

  // One payload word, read as vertex or done packet
  typedef union packed {
    struct packed {
      logic [engine_id_width-1:0] engine_id;
      logic [vertex_id_width-1:0] vertex_id;
    } vertex;
    struct packed {
      logic [engine_id_width-1:0] engine_id;
      logic [status_width-1:0]    status_flags;
      logic [count_width-1:0]     processed_count;
    } done;
  } control_payload_u;

endpackage : glay_control_pkg

`default_nettype wire

// File: rtl/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter int DEPTH       = 16,
  parameter int WIDTH       = 32,
  parameter int PROG_THRESH = 12
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             valid,
  output logic             empty,
  output logic             full,
  output logic             prog_full
);

  localparam int ADDR_WIDTH  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]       mem [DEPTH];
  logic [ADDR_WIDTH-1:0]  wr_ptr;
  logic [ADDR_WIDTH-1:0]  rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   do_write;
  logic                   do_read;

  // Overflow and underflow are blocked here
  assign do_write = wr_en && !full;
  assign do_read  = rd_en && !empty;

  // Flags straight from the occupancy count
  assign empty     = (count == '0);
  assign full      = (count == COUNT_WIDTH'(DEPTH));
  assign prog_full = (count >= COUNT_WIDTH'(PROG_THRESH));

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      if (do_write) begin
        // Wrap at DEPTH, which need not be a power of two
        wr_ptr <= (wr_ptr == ADDR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == ADDR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Read data shows up one cycle after the pop
      valid <= do_read;
    end
  end

  // Storage and read register
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
    if (do_read) begin
      dout <= mem[rd_ptr];
    end
  end

endmodule : sync_fifo

`default_nettype wire

// File: rtl/round_robin_bus_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module round_robin_bus_arbiter #(
  parameter int NUM_REQUESTORS = 4,
  parameter int BUS_WIDTH      = 33
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic [NUM_REQUESTORS-1:0] arbiter_request,
  input  logic [NUM_REQUESTORS-1:0] bus_valid,
  input  logic [BUS_WIDTH-1:0]      bus_in [NUM_REQUESTORS],
  output logic [NUM_REQUESTORS-1:0] arbiter_grant,
  output logic                      bus_out_valid,
  output logic [BUS_WIDTH-1:0]      bus_out
);

  localparam int IDX_WIDTH = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

  logic [NUM_REQUESTORS-1:0] masked_request;
  logic [NUM_REQUESTORS-1:0] next_grant;
  logic [IDX_WIDTH-1:0]      last_idx;
  logic [IDX_WIDTH-1:0]      next_idx;
  logic                      found;
  int                        scan_idx;
  logic [BUS_WIDTH-1:0]      bus_mux;

  // ------------------------------------------------
  // Grant selection
  // ------------------------------------------------
  always_comb begin
    // Requestor popped this cycle sits out the next one
    masked_request = arbiter_request & ~arbiter_grant;
    next_grant     = '0;
    next_idx       = last_idx;
    found          = 1'b0;
    scan_idx       = 0;
    // Scan starts just after the last winner
    for (int k = 1; k <= NUM_REQUESTORS; k++) begin
      scan_idx = int'(last_idx) + k;
      if (scan_idx >= NUM_REQUESTORS) begin
        scan_idx = scan_idx - NUM_REQUESTORS;
      end
      if (!found && masked_request[scan_idx]) begin
        found                = 1'b1;
        next_grant[scan_idx] = 1'b1;
        next_idx             = scan_idx[IDX_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arbiter_grant <= '0;
      // First grant goes to requestor 0
      last_idx      <= IDX_WIDTH'(NUM_REQUESTORS - 1);
    end else begin
      arbiter_grant <= next_grant;
      if (found) begin
        last_idx <= next_idx;
      end
    end
  end

  // ------------------------------------------------
  // Bus multiplexer
  // ------------------------------------------------
  // At most one source is valid per cycle, so an OR mux suffices
  always_comb begin
    bus_mux = '0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      bus_mux = bus_mux | (bus_in[i] & {BUS_WIDTH{bus_valid[i]}});
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      bus_out_valid <= 1'b0;
    end else begin
      bus_out_valid <= |bus_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    bus_out <= bus_mux;
  end

endmodule : round_robin_bus_arbiter

`default_nettype wire

// File: rtl/control_request_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module control_request_arbiter
  import glay_control_pkg::*;
#(
  parameter int NUM_REQUESTORS    = 4,
  parameter int INPUT_FIFO_DEPTH  = 16,
  parameter int OUTPUT_FIFO_DEPTH = 32
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic [NUM_REQUESTORS-1:0] request_valid,
  input  logic [NUM_REQUESTORS-1:0] request_kind,
  input  control_payload_u          request_payload [NUM_REQUESTORS],
  output logic [NUM_REQUESTORS-1:0] request_ready,
  input  logic                      out_ready,
  output logic                      out_valid,
  output logic                      out_kind,
  output control_payload_u          out_payload
);

  // Slots kept free for beats still in the pipeline
  localparam int FIFO_MARGIN = 4;

  // Input stage
  logic [NUM_REQUESTORS-1:0] req_valid_reg;
  logic [packet_width-1:0]   req_packet_reg [NUM_REQUESTORS];

  // Per-requestor FIFOs
  logic [NUM_REQUESTORS-1:0] in_rd_en;
  logic [NUM_REQUESTORS-1:0] in_valid;
  logic [NUM_REQUESTORS-1:0] in_empty;
  logic [NUM_REQUESTORS-1:0] in_prog_full;
  logic [packet_width-1:0]   in_dout [NUM_REQUESTORS];

  // Arbiter
  logic [NUM_REQUESTORS-1:0] arbiter_request;
  logic [NUM_REQUESTORS-1:0] arbiter_grant;
  logic                      arb_out_valid;
  logic [packet_width-1:0]   arb_out;

  // Output FIFO
  logic                      out_ready_reg;
  logic                      out_rd_en;
  logic                      out_fifo_valid;
  logic                      out_empty;
  logic                      out_prog_full;
  logic [packet_width-1:0]   out_dout;

  // ------------------------------------------------
  // Input registers
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_valid_reg <= '0;
      out_ready_reg <= 1'b0;
    end else begin
      req_valid_reg <= request_valid;
      out_ready_reg <= out_ready;
    end
  end

  // Kind bit goes on top of the payload
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      req_packet_reg[i] <= {request_kind[i], request_payload[i]};
    end
  end

  // ------------------------------------------------
  // Per-requestor FIFOs
  // ------------------------------------------------
  for (genvar i = 0; i < NUM_REQUESTORS; i++) begin : gen_in_fifo
    // Pop only the granted, non-empty FIFO
    assign in_rd_en[i] = arbiter_grant[i] & ~in_empty[i];
    // Hold off the arbiter while the output FIFO is nearly full
    assign arbiter_request[i] = ~in_empty[i] & ~out_prog_full;

    sync_fifo #(
      .DEPTH      (INPUT_FIFO_DEPTH),
      .WIDTH      (packet_width),
      .PROG_THRESH(INPUT_FIFO_DEPTH - FIFO_MARGIN)
    ) u_in_fifo (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .din           (req_packet_reg[i]),
      .wr_en         (req_valid_reg[i]),
      .rd_en         (in_rd_en[i]),
      .dout          (in_dout[i]),
      .valid         (in_valid[i]),
      .empty         (in_empty[i]),
      .full          (),
      .prog_full     (in_prog_full[i])
    );
  end

  // FIFO heads onto one registered bus
  round_robin_bus_arbiter #(
    .NUM_REQUESTORS(NUM_REQUESTORS),
    .BUS_WIDTH     (packet_width)
  ) u_arbiter (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .arbiter_request(arbiter_request),
    .bus_valid      (in_valid),
    .bus_in         (in_dout),
    .arbiter_grant  (arbiter_grant),
    .bus_out_valid  (arb_out_valid),
    .bus_out        (arb_out)
  );

  // ------------------------------------------------
  // Output FIFO
  // ------------------------------------------------
  assign out_rd_en = out_ready_reg & ~out_empty;

  sync_fifo #(
    .DEPTH      (OUTPUT_FIFO_DEPTH),
    .WIDTH      (packet_width),
    .PROG_THRESH(OUTPUT_FIFO_DEPTH - FIFO_MARGIN)
  ) u_out_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (arb_out),
    .wr_en         (arb_out_valid),
    .rd_en         (out_rd_en),
    .dout          (out_dout),
    .valid         (out_fifo_valid),
    .empty         (out_empty),
    .full          (),
    .prog_full     (out_prog_full)
  );

  // ------------------------------------------------
  // Ready feedback and output registers
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_ready <= '0;
      out_valid     <= 1'b0;
    end else begin
      // Own FIFO and shared FIFO must both have room
      request_ready <= ~in_prog_full & {NUM_REQUESTORS{~out_prog_full}};
      out_valid     <= out_fifo_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_kind    <= out_dout[packet_width-1];
    out_payload <= out_dout[payload_width-1:0];
  end

endmodule : control_request_arbiter

`default_nettype wire

// File: rtl/vertex_control_engine.sv
`timescale 1ns/100ps
`default_nettype none

module vertex_control_engine
  import glay_control_pkg::*;
#(
  parameter int ENGINE_ID = 0
) (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic                       cmd_valid,
  output logic                       cmd_ready,
  input  logic [vertex_id_width-1:0] cmd_first_vertex,
  input  logic [count_width-1:0]     cmd_count,
  input  logic                       request_ready,
  output logic                       request_valid,
  output logic                       request_kind,
  output control_payload_u           request_payload
);

  // FSM encoding
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_issue = 2'd1;
  localparam logic [1:0] st_done  = 2'd2;

  logic [1:0]                 state;
  logic [vertex_id_width-1:0] vertex_id;
  logic [count_width-1:0]     remaining;
  logic [count_width-1:0]     total_count;

  assign cmd_ready = (state == st_idle);

  // One beat per cycle, only while the arbiter has room
  assign request_valid = request_ready && ((state == st_issue) || (state == st_done));
  assign request_kind  = (state == st_done) ? packet_kind_done : packet_kind_vertex;

  always_comb begin
    if (state == st_done) begin
      request_payload.done.engine_id       = engine_id_width'(ENGINE_ID);
      // No status reported yet
      request_payload.done.status_flags    = '0;
      request_payload.done.processed_count = total_count;
    end else begin
      request_payload.vertex.engine_id = engine_id_width'(ENGINE_ID);
      request_payload.vertex.vertex_id = vertex_id;
    end
  end

  // ------------------------------------------------
  // Command FSM and vertex counter
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          // Zero count goes straight to the done packet
          if (cmd_valid) begin
            state <= (cmd_count == '0) ? st_done : st_issue;
          end
        end
        st_issue: begin
          if (request_ready && (remaining == count_width'(1))) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (request_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Counters load on a command and step on each vertex beat
  always_ff @(posedge ap_clk) begin
    if (cmd_valid && cmd_ready) begin
      vertex_id   <= cmd_first_vertex;
      remaining   <= cmd_count;
      total_count <= cmd_count;
    end else if ((state == st_issue) && request_ready) begin
      vertex_id <= vertex_id + 1'b1;
      remaining <= remaining - 1'b1;
    end
  end

endmodule : vertex_control_engine

`default_nettype wire

// File: rtl/glay_control_top.sv
`timescale 1ns/100ps
`default_nettype none

module glay_control_top
  import glay_control_pkg::*;
#(
  parameter int NUM_ENGINES       = 4,
  parameter int INPUT_FIFO_DEPTH  = 16,
  parameter int OUTPUT_FIFO_DEPTH = 32
) (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic [NUM_ENGINES-1:0]     cmd_valid,
  output logic [NUM_ENGINES-1:0]     cmd_ready,
  input  logic [vertex_id_width-1:0] cmd_first_vertex [NUM_ENGINES],
  input  logic [count_width-1:0]     cmd_count [NUM_ENGINES],
  input  logic                       out_ready,
  output logic                       out_valid,
  output logic                       out_kind,
  output control_payload_u           out_payload
);

  // ------------------------------------------------
  // Engine to arbiter wires
  // ------------------------------------------------
  logic [NUM_ENGINES-1:0] request_valid;
  logic [NUM_ENGINES-1:0] request_kind;
  logic [NUM_ENGINES-1:0] request_ready;
  control_payload_u       request_payload [NUM_ENGINES];

  // One engine per arbiter port, engine id from the index
  for (genvar i = 0; i < NUM_ENGINES; i++) begin : gen_engine
    vertex_control_engine #(
      .ENGINE_ID(i)
    ) u_engine (
      .ap_clk          (ap_clk),
      .areset_control  (areset_control),
      .cmd_valid       (cmd_valid[i]),
      .cmd_ready       (cmd_ready[i]),
      .cmd_first_vertex(cmd_first_vertex[i]),
      .cmd_count       (cmd_count[i]),
      .request_ready   (request_ready[i]),
      .request_valid   (request_valid[i]),
      .request_kind    (request_kind[i]),
      .request_payload (request_payload[i])
    );
  end

  // Funnel into the shared control bus
  control_request_arbiter #(
    .NUM_REQUESTORS   (NUM_ENGINES),
    .INPUT_FIFO_DEPTH (INPUT_FIFO_DEPTH),
    .OUTPUT_FIFO_DEPTH(OUTPUT_FIFO_DEPTH)
  ) u_request_arbiter (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .request_valid  (request_valid),
    .request_kind   (request_kind),
    .request_payload(request_payload),
    .request_ready  (request_ready),
    .out_ready      (out_ready),
    .out_valid      (out_valid),
    .out_kind       (out_kind),
    .out_payload    (out_payload)
  );

endmodule : glay_control_top

`default_nettype wire

// File: test/glay_control_tb.sv
`timescale 1ns/100ps
`default_nettype none

module glay_control_tb
  import glay_control_pkg::*;
();

  localparam int NUM_ENGINES = 4;

  // DUT ports
  logic                       ap_clk;
  logic                       areset_control;
  logic [NUM_ENGINES-1:0]     cmd_valid;
  logic [NUM_ENGINES-1:0]     cmd_ready;
  logic [vertex_id_width-1:0] cmd_first_vertex [NUM_ENGINES];
  logic [count_width-1:0]     cmd_count [NUM_ENGINES];
  logic                       out_ready;
  logic                       out_valid;
  logic                       out_kind;
  control_payload_u           out_payload;

  // Pending commands and expected packets, per engine
  logic [vertex_id_width-1:0] cmd_first_q [NUM_ENGINES][$];
  logic [count_width-1:0]     cmd_count_q [NUM_ENGINES][$];
  logic                       exp_kind_q [NUM_ENGINES][$];
  control_payload_u           exp_payload_q [NUM_ENGINES][$];

  string test_name;
  string bp_mode;
  logic  bp_random;
  int    received;
  int    packets_checked;
  int    value_errors;
  int    other_errors;
  int    cycle_count;
  int    deadline;

  glay_control_top #(
    .NUM_ENGINES      (NUM_ENGINES),
    .INPUT_FIFO_DEPTH (16),
    .OUTPUT_FIFO_DEPTH(32)
  ) uut (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_first_vertex(cmd_first_vertex),
    .cmd_count       (cmd_count),
    .out_ready       (out_ready),
    .out_valid       (out_valid),
    .out_kind        (out_kind),
    .out_payload     (out_payload)
  );

  // 4 ns period
  always #2 ap_clk = ~ap_clk;

  // Consumer drops ready about a third of the time in random mode
  always @(posedge ap_clk) begin
    out_ready <= bp_random ? (($urandom % 3) != 0) : 1'b1;
  end

  // Run ends if a test overruns its cycle budget
  always @(posedge ap_clk) begin : watchdog
    cycle_count++;
    if (deadline != 0 && cycle_count > deadline) begin
      $display("Timeout: test %s did not finish within its cycle limit", test_name);
      $display("Checks failed");
      $finish;
    end
  end

  // ------------------------------------------------
  // Compare tasks
  // ------------------------------------------------
  task automatic check_kind(input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail %s kind: expected %0b actual %0b", test_name, expected, actual);
    end
  endtask

  task automatic check_vertex(input control_payload_u expected, input control_payload_u actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail %s vertex: expected engine %0d id %07h actual engine %0d id %07h",
               test_name, expected.vertex.engine_id, expected.vertex.vertex_id,
               actual.vertex.engine_id, actual.vertex.vertex_id);
    end
  endtask

  task automatic check_done(input control_payload_u expected, input control_payload_u actual);
    if (actual !== expected) begin
      value_errors++;
      // Expected half, then actual half on the same line
      $write("Fail %s done: expected engine %0d flags %03h count %0d", test_name,
             expected.done.engine_id, expected.done.status_flags,
             expected.done.processed_count);
      $display(" actual engine %0d flags %03h count %0d", actual.done.engine_id,
               actual.done.status_flags, actual.done.processed_count);
    end
  endtask

  task automatic check_ready(input logic [NUM_ENGINES-1:0] expected,
                             input logic [NUM_ENGINES-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail %s cmd_ready: expected %b actual %b", test_name, expected, actual);
    end
  endtask

  task automatic check_valid(input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail %s out_valid: expected %0b actual %0b", test_name, expected, actual);
    end
  endtask

  task automatic check_total(input int expected, input int actual);
    if (actual != expected) begin
      value_errors++;
      $display("Fail %s total: expected %0d actual %0d", test_name, expected, actual);
    end
  endtask

  // ------------------------------------------------
  // Expected packets from a command
  // ------------------------------------------------
  task automatic expand_command(input int eng, input int unsigned first, input int count);
    control_payload_u pkt;
    // Vertex ids first .. first + count - 1
    for (int i = 0; i < count; i++) begin
      pkt.vertex.engine_id = engine_id_width'(eng);
      pkt.vertex.vertex_id = vertex_id_width'(first + i);
      exp_kind_q[eng].push_back(packet_kind_vertex);
      exp_payload_q[eng].push_back(pkt);
    end
    // Then one done packet carrying the count
    pkt.done.engine_id       = engine_id_width'(eng);
    pkt.done.status_flags    = '0;
    pkt.done.processed_count = count_width'(count);
    exp_kind_q[eng].push_back(packet_kind_done);
    exp_payload_q[eng].push_back(pkt);
    cmd_first_q[eng].push_back(vertex_id_width'(first));
    cmd_count_q[eng].push_back(count_width'(count));
  endtask

  // Output packets against each engine's own order
  always @(negedge ap_clk) begin : packet_monitor
    int               eng;
    logic             exp_kind;
    control_payload_u exp_payload;
    if (out_valid === 1'b1) begin
      eng = int'(out_payload.vertex.engine_id);
      if (eng >= NUM_ENGINES) begin
        other_errors++;
        $display("Test %s: packet carries unknown engine id %0d", test_name, eng);
      end else if (exp_kind_q[eng].size() == 0) begin
        other_errors++;
        $display("Test %s: extra packet from engine %0d", test_name, eng);
      end else begin
        exp_kind    = exp_kind_q[eng].pop_front();
        exp_payload = exp_payload_q[eng].pop_front();
        check_kind(exp_kind, out_kind);
        if (exp_kind == packet_kind_done) begin
          check_done(exp_payload, out_payload);
        end else begin
          check_vertex(exp_payload, out_payload);
        end
      end
      received++;
      packets_checked++;
    end
  end

  // ------------------------------------------------
  // Command driver for one test
  // ------------------------------------------------
  task automatic run_test(input int expected_total);
    bit busy;
    bit pending;
    received = 0;
    // Budget of 8 cycles per packet plus slack
    deadline = cycle_count + expected_total * 8 + 200;
    bp_random <= (bp_mode == "random");
    busy = 1'b1;
    while (busy) begin
      @(posedge ap_clk);
      pending = 1'b0;
      for (int e = 0; e < NUM_ENGINES; e++) begin
        if (cmd_valid[e] && cmd_ready[e]) begin
          // Handshake on this edge
          cmd_valid[e] <= 1'b0;
        end else if (!cmd_valid[e] && cmd_first_q[e].size() != 0) begin
          cmd_valid[e]        <= 1'b1;
          cmd_first_vertex[e] <= cmd_first_q[e].pop_front();
          cmd_count[e]        <= cmd_count_q[e].pop_front();
        end
        if (cmd_first_q[e].size() != 0) begin
          pending = 1'b1;
        end
      end
      busy = (received < expected_total) || pending || (cmd_valid != '0) || (cmd_ready != '1);
    end
    // Extra packets would still show up here
    repeat (40) @(posedge ap_clk);
    check_total(expected_total, received);
    for (int e = 0; e < NUM_ENGINES; e++) begin
      if (exp_kind_q[e].size() != 0) begin
        other_errors++;
        $display("Test %s: engine %0d is missing %0d packets", test_name, e,
                 exp_kind_q[e].size());
        exp_kind_q[e].delete();
        exp_payload_q[e].delete();
      end
    end
    bp_random <= 1'b0;
    deadline = 0;
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin : main
    int          fd;
    string       line;
    string       keyword;
    string       name;
    int          eng;
    int unsigned first;
    int          count;
    int          total;
    ap_clk         = 1'b0;
    areset_control = 1'b1;
    cmd_valid      = '0;
    out_ready      = 1'b0;
    for (int e = 0; e < NUM_ENGINES; e++) begin
      cmd_first_vertex[e] = '0;
      cmd_count[e]        = '0;
    end
    bp_random       = 1'b0;
    bp_mode         = "none";
    test_name       = "reset";
    received        = 0;
    packets_checked = 0;
    value_errors    = 0;
    other_errors    = 0;
    cycle_count     = 0;
    deadline        = 0;
    void'($urandom(32'h4c2344ad));

    repeat (8) @(posedge ap_clk);
    areset_control <= 1'b0;

    // Idle after reset, no commands yet
    repeat (10) begin
      @(negedge ap_clk);
      check_valid(1'b0, out_valid);
      check_ready('1, cmd_ready);
    end

    fd = $fopen("test/control_input.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Cannot open the stimulus file test/control_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ($sscanf(line, "%s", keyword) == 1 && keyword.getc(0) != "#") begin
          if (keyword == "test") begin
            void'($sscanf(line, "%s %s %s", keyword, name, bp_mode));
            test_name = name;
          end else if (keyword == "cmd") begin
            void'($sscanf(line, "%s %d %h %d", keyword, eng, first, count));
            expand_command(eng, first, count);
          end else if (keyword == "expect") begin
            void'($sscanf(line, "%s %d", keyword, total));
            run_test(total);
          end else begin
            other_errors++;
            $display("Unknown record in stimulus file: %s", keyword);
          end
        end
      end
      $fclose(fd);
    end

    $display("Packets checked %0d, value errors %0d, other errors %0d",
             packets_checked, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : glay_control_tb

`default_nettype wire

// File: compile.f
rtl/glay_control_pkg.sv
rtl/sync_fifo.sv
rtl/round_robin_bus_arbiter.sv
rtl/control_request_arbiter.sv
rtl/vertex_control_engine.sv
rtl/glay_control_top.sv
test/glay_control_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := glay_control_tb
FILELIST := compile.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

// File: test/control_input.txt
# Columns: test <name> <back-pressure none|random>
#          cmd <engine> <first vertex, hex> <count, decimal>
#          expect <total packets, decimal>
test single_engine0 none
cmd 0 0000100 5
expect 6
test single_engine3 none
cmd 3 0abcdef 3
expect 4
test concurrent none
cmd 0 0001000 20
cmd 1 0002000 17
cmd 2 0003000 25
cmd 3 0004000 12
expect 78
test backpressure random
cmd 0 0005000 40
cmd 1 0006000 33
cmd 2 0007000 1
cmd 3 0008000 50
expect 128
test zero_count none
cmd 2 0009000 0
expect 1
test zero_then_next none
cmd 1 0009100 0
cmd 1 0009200 4
expect 6
test mixed_random random
cmd 0 0000000 0
cmd 1 00a0000 9
cmd 1 00b0000 7
cmd 2 0c00000 30
cmd 3 fffff00 2
expect 53
